// ==== design/dircc_types_pkg.sv ====
package dircc_types_pkg;

    // Device state layout, byte 0 is the low byte of the main state
    localparam int DEV_MEM_BYTES = 12;
    localparam int MEM_WIDTH = 16;
    localparam int MSG_WIDTH = 32;

    // Highest host address whose two bytes both fall inside the state
    localparam int MAX_WORD_ADDR = DEV_MEM_BYTES - 2;

    typedef logic [7:0] mem_byte_t;

    // First member sits in the high bits of the packed vector
    typedef struct packed {
        logic [63:0] user_state;        // Bytes 11:4
        logic [15:0] dircc_state_extra; // Bytes 3:2
        logic [15:0] dircc_state;       // Bytes 1:0
    } device_state_t;

    typedef enum logic [7:0] {
        OP_SET_STATE = 8'h01,
        OP_SET_EXTRA = 8'h02,
        OP_ADD_STATE = 8'h03,
        OP_SET_USER  = 8'h04
    } msg_opcode_e;

    typedef struct packed {
        msg_opcode_e opcode;
        logic [7:0]  reserved;
        logic [15:0] value;
    } msg_hdr_t;

    // A beat is either a header or a user state data word
    typedef union packed {
        msg_hdr_t               hdr;
        logic [MSG_WIDTH-1:0]   raw;
    } msg_word_u;

    // Bytes occupied by each field
    localparam int STATE_BYTES = $bits(logic [15:0]) / 8;
    localparam int EXTRA_BYTES = $bits(logic [15:0]) / 8;
    localparam int USER_BYTES = $bits(logic [63:0]) / 8;

    // Twelve bytes in all
    localparam int STATE_BITS = 8 * DEV_MEM_BYTES;

    // Number of raw beats that follow an OP_SET_USER header
    localparam int USER_BEATS = USER_BYTES / (MSG_WIDTH / 8);

endpackage : dircc_types_pkg

// ==== design/dircc_mem_if.sv ====
`timescale 1ns/10ps

interface dircc_mem_if
    import dircc_types_pkg::*;
#(
    parameter int ADDRESS_WIDTH = 4
) ();

    logic [ADDRESS_WIDTH-1:0] address;  // Byte address
    logic                     write;
    logic [MEM_WIDTH-1:0]     writedata;
    logic [MEM_WIDTH-1:0]     readdata;

    modport host (
        output address,
        output write,
        output writedata,
        input  readdata
    );

    modport register (
        input  address,
        input  write,
        input  writedata,
        output readdata
    );

endinterface : dircc_mem_if

// ==== design/dircc_status_register.sv ====
`timescale 1ns/10ps

module dircc_status_register
    import dircc_types_pkg::*;
#(
    parameter int ADDRESS_WIDTH = 4
) (
    input  logic                clk,
    input  logic                reset_n,

    dircc_mem_if.register       mem,

    output device_state_t       read_state,

    input  device_state_t       write_state,
    input  logic                write_state_valid
);

    mem_byte_t dev_mem [DEV_MEM_BYTES];

    logic                  addr_ok;
    logic [STATE_BITS-1:0] stored_bits;

    assign addr_ok = (mem.address <= MAX_WORD_ADDR);

    // Byte i of the state lands in bits 8*i+7:8*i
    always_comb begin
        for (int i = 0; i < DEV_MEM_BYTES; i++) begin
            stored_bits[8*i +: 8] = dev_mem[i];
        end
    end

    // Internal update is visible the same cycle it is presented
    assign read_state = write_state_valid ? write_state : device_state_t'(stored_bits);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < DEV_MEM_BYTES; i++) begin
                dev_mem[i] <= '0;
            end
            mem.readdata <= '0;
        end else begin
            if (write_state_valid) begin
                // Whole state replaced
                for (int i = 0; i < DEV_MEM_BYTES; i++) begin
                    dev_mem[i] <= write_state[8*i +: 8];
                end
            end else if (mem.write && addr_ok) begin
                dev_mem[mem.address + 1] <= mem.writedata[15:8];
                dev_mem[mem.address]     <= mem.writedata[7:0];
            end

            // Read returns the bytes as held before this edge
            if (addr_ok) begin
                mem.readdata <= {dev_mem[mem.address + 1], dev_mem[mem.address]};
            end else begin
                mem.readdata <= '0;
            end
        end
    end

endmodule : dircc_status_register

// ==== design/dircc_msg_handler.sv ====
`timescale 1ns/10ps

module dircc_msg_handler
    import dircc_types_pkg::*;
(
    input  logic            clk,
    input  logic            reset_n,

    input  logic            msg_valid,
    input  msg_word_u       msg_data,
    output logic            msg_busy,

    input  device_state_t   read_state,
    output device_state_t   write_state,
    output logic            write_state_valid
);

    logic [1:0]     beat_cnt;       // Raw beats still expected
    logic           pend_valid;
    msg_opcode_e    pend_op;
    logic [15:0]    pend_value;
    logic [63:0]    pend_user;

    logic           take_hdr;
    logic           take_raw;
    device_state_t  next_state;

    // Busy from the OP_SET_USER header until its update is gone
    assign msg_busy = (beat_cnt != 2'd0)
                    || (pend_valid && (pend_op == OP_SET_USER))
                    || write_state_valid;

    // New header only once the previous update has left the pipeline
    assign take_hdr = msg_valid && !msg_busy && !pend_valid;
    assign take_raw = msg_valid && (beat_cnt != 2'd0);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            beat_cnt   <= 2'd0;
            pend_valid <= 1'b0;
        end else begin
            pend_valid <= 1'b0;
            if (take_hdr) begin
                case (msg_data.hdr.opcode)
                    OP_SET_STATE, OP_SET_EXTRA, OP_ADD_STATE: pend_valid <= 1'b1;
                    OP_SET_USER: beat_cnt <= 2'(USER_BEATS);
                    default: ;                              // Unknown opcode dropped
                endcase
            end else if (take_raw) begin
                beat_cnt <= beat_cnt - 2'd1;
                if (beat_cnt == 2'd1) begin
                    pend_valid <= 1'b1;                     // Low word completes it
                end
            end
        end
    end

    // Payload of the pending update
    always_ff @(posedge clk) begin
        if (take_hdr) begin
            pend_op    <= msg_data.hdr.opcode;
            pend_value <= msg_data.hdr.value;
        end
        if (take_raw) begin
            pend_user <= {pend_user[31:0], msg_data.raw};   // High word first
        end
    end

    // Only the addressed field differs from the current state
    always_comb begin
        next_state = read_state;
        case (pend_op)
            OP_SET_STATE: next_state.dircc_state = pend_value;
            OP_SET_EXTRA: next_state.dircc_state_extra = pend_value;
            OP_ADD_STATE: next_state.dircc_state = read_state.dircc_state + pend_value;
            OP_SET_USER:  next_state.user_state = pend_user;
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            write_state_valid <= 1'b0;
        end else begin
            write_state_valid <= pend_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pend_valid) begin
            write_state <= next_state;
        end
    end

endmodule : dircc_msg_handler

// ==== design/dircc_host_arbiter.sv ====
`timescale 1ns/10ps

module dircc_host_arbiter
    import dircc_types_pkg::*;
#(
    parameter int ADDRESS_WIDTH = 4
) (
    input  logic                        clk,
    input  logic                        reset_n,

    input  logic [ADDRESS_WIDTH-1:0]    host_address,
    input  logic                        host_write,
    input  logic [MEM_WIDTH-1:0]        host_writedata,
    output logic [MEM_WIDTH-1:0]        host_readdata,
    output logic                        host_busy,

    input  logic                        write_state_valid,

    dircc_mem_if.host                   mem
);

    logic                       buf_valid;
    logic [ADDRESS_WIDTH-1:0]   buf_address;
    logic [MEM_WIDTH-1:0]       buf_data;
    logic                       collide;

    // Internal update wins the register port
    assign collide = host_write && write_state_valid;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            buf_valid <= 1'b0;
        end else begin
            buf_valid <= collide;   // Replay lasts one cycle
        end
    end

    always_ff @(posedge clk) begin
        if (collide) begin
            buf_address <= host_address;
            buf_data    <= host_writedata;
        end
    end

    // Replay overrides the live host address for one cycle
    assign mem.address   = buf_valid ? buf_address : host_address;
    assign mem.writedata = buf_valid ? buf_data : host_writedata;
    assign mem.write     = buf_valid || (host_write && !write_state_valid);

    assign host_readdata = mem.readdata;
    assign host_busy     = buf_valid;

endmodule : dircc_host_arbiter

// ==== design/dircc_device_top.sv ====
`timescale 1ns/10ps

module dircc_device_top
    import dircc_types_pkg::*;
#(
    parameter int ADDRESS_WIDTH = 4
) (
    input  logic                        clk,
    input  logic                        reset_n,

    input  logic [ADDRESS_WIDTH-1:0]    host_address,
    input  logic                        host_write,
    input  logic [MEM_WIDTH-1:0]        host_writedata,
    output logic [MEM_WIDTH-1:0]        host_readdata,
    output logic                        host_busy,

    input  logic                        msg_valid,
    input  logic [MSG_WIDTH-1:0]        msg_data,
    output logic                        msg_busy,

    output logic [15:0]                 state_main,
    output logic [15:0]                 state_extra,
    output logic [63:0]                 state_user
);

    device_state_t read_state;
    device_state_t write_state;
    logic          write_state_valid;

    dircc_mem_if #(.ADDRESS_WIDTH(ADDRESS_WIDTH)) mem0 ();

    dircc_host_arbiter #(.ADDRESS_WIDTH(ADDRESS_WIDTH)) arb0 (
        .clk               (clk),
        .reset_n           (reset_n),
        .host_address      (host_address),
        .host_write        (host_write),
        .host_writedata    (host_writedata),
        .host_readdata     (host_readdata),
        .host_busy         (host_busy),
        .write_state_valid (write_state_valid),
        .mem               (mem0.host)
    );

    dircc_msg_handler hdl0 (
        .clk               (clk),
        .reset_n           (reset_n),
        .msg_valid         (msg_valid),
        .msg_data          (msg_data),
        .msg_busy          (msg_busy),
        .read_state        (read_state),
        .write_state       (write_state),
        .write_state_valid (write_state_valid)
    );

    dircc_status_register #(.ADDRESS_WIDTH(ADDRESS_WIDTH)) reg0 (
        .clk               (clk),
        .reset_n           (reset_n),
        .mem               (mem0.register),
        .read_state        (read_state),
        .write_state       (write_state),
        .write_state_valid (write_state_valid)
    );

    // Outputs follow the bypassed state
    assign state_main  = read_state.dircc_state;
    assign state_extra = read_state.dircc_state_extra;
    assign state_user  = read_state.user_state;

endmodule : dircc_device_top

// ==== tests/dircc_device_sva.sv ====
`timescale 1ns/10ps

module dircc_device_sva (
    input logic clk,
    input logic reset_n,
    input logic write_state_valid,
    input logic mem_write,
    input logic host_busy
);

    // Register port has a single writer in any cycle
    a_one_writer: assert property (@(posedge clk) disable iff (!reset_n)
        !(write_state_valid && mem_write))
        else $error("internal update and memory write in the same cycle");

    a_busy_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        host_busy |=> !host_busy)
        else $error("host_busy held for more than one cycle");

    a_update_one_cycle: assert property (@(posedge clk) disable iff (!reset_n)
        write_state_valid |=> !write_state_valid)
        else $error("write_state_valid held for more than one cycle");

endmodule : dircc_device_sva

// Arbiter sees the update strobe, the register write and the busy level
bind dircc_host_arbiter dircc_device_sva sva0 (
    .clk               (clk),
    .reset_n           (reset_n),
    .write_state_valid (write_state_valid),
    .mem_write         (mem.write),
    .host_busy         (host_busy)
);

// ==== tests/dircc_device_tb.sv ====
`timescale 1ns/10ps

module dircc_device_tb
    import dircc_types_pkg::*;
();

    localparam int AW = 4;
    localparam int MAX_CYCLES = 4000;   // About twice the stimulus length
    localparam int KIND_STATE = 0;
    localparam int KIND_WORD = 1;
    localparam int KIND_BUSY = 2;

    typedef struct {
        int            due;
        int            kind;
        device_state_t st;
        logic [15:0]   word;
        logic [1:0]    busy;            // {host_busy, msg_busy}
    } expect_t;

    logic                  clk;
    logic                  reset_n;
    logic [AW-1:0]         host_address;
    logic                  host_write;
    logic [MEM_WIDTH-1:0]  host_writedata;
    logic [MEM_WIDTH-1:0]  host_readdata;
    logic                  host_busy;
    logic                  msg_valid;
    msg_word_u             msg_data;
    logic                  msg_busy;
    logic [15:0]           state_main;
    logic [15:0]           state_extra;
    logic [63:0]           state_user;

    logic [STATE_BITS-1:0] model;       // Byte i at bits 8*i+7:8*i
    expect_t               exp_q[$];
    int                    cyc = 0;

    dircc_device_top #(.ADDRESS_WIDTH(AW)) dut0 (
        .clk            (clk),
        .reset_n        (reset_n),
        .host_address   (host_address),
        .host_write     (host_write),
        .host_writedata (host_writedata),
        .host_readdata  (host_readdata),
        .host_busy      (host_busy),
        .msg_valid      (msg_valid),
        .msg_data       (msg_data),
        .msg_busy       (msg_busy),
        .state_main     (state_main),
        .state_extra    (state_extra),
        .state_user     (state_user)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Host write when from_host is set, otherwise one decoded message
    function automatic logic [STATE_BITS-1:0] ref_apply(input logic [STATE_BITS-1:0] m,
            input bit from_host, input logic [7:0] op, input logic [15:0] value,
            input logic [63:0] user, input logic [AW-1:0] addr);
        logic [STATE_BITS-1:0] r;
        r = m;
        if (from_host) begin
            if (addr <= 4'd10) begin
                r[8*addr +: 16] = value;    // Low byte at addr
            end
        end else begin
            case (op)
                OP_SET_STATE: r[15:0] = value;
                OP_SET_EXTRA: r[31:16] = value;
                OP_ADD_STATE: r[15:0] = m[15:0] + value;
                OP_SET_USER:  r[95:32] = user;
                default: ;
            endcase
        end
        return r;
    endfunction

    function automatic logic [15:0] ref_read(input logic [STATE_BITS-1:0] m,
            input logic [AW-1:0] addr);
        return (addr <= 4'd10) ? m[8*addr +: 16] : 16'h0000;
    endfunction

    function automatic device_state_t to_state(input logic [STATE_BITS-1:0] m);
        device_state_t s;
        s.dircc_state       = m[15:0];
        s.dircc_state_extra = m[31:16];
        s.user_state        = m[95:32];
        return s;
    endfunction

    task automatic check_state(input device_state_t act, input device_state_t exp, input int c);
        if (act !== exp) begin
            $display("FAIL at %0t: cycle %0d state main %h extra %h user %h, expected %h %h %h",
                $time, c, act.dircc_state, act.dircc_state_extra, act.user_state,
                exp.dircc_state, exp.dircc_state_extra, exp.user_state);
            $display("FAIL: see errors above");
            $fatal(1, "state mismatch");
        end
    endtask

    task automatic check_readdata(input logic [15:0] act, input logic [15:0] exp, input int c);
        if (act !== exp) begin
            $display("FAIL at %0t: cycle %0d host_readdata %h, expected %h", $time, c, act, exp);
            $display("FAIL: see errors above");
            $fatal(1, "read data mismatch");
        end
    endtask

    task automatic check_busy(input logic [1:0] act, input logic [1:0] exp, input int c);
        if (act !== exp) begin
            $display("FAIL at %0t: cycle %0d host_busy/msg_busy %b, expected %b",
                $time, c, act, exp);
            $display("FAIL: see errors above");
            $fatal(1, "busy level mismatch");
        end
    endtask

    task automatic expect_result(input int ahead, input int kind, input logic [15:0] word,
            input logic [1:0] busy);
        expect_t e;
        e.due  = cyc + ahead;
        e.kind = kind;
        e.st   = to_state(model);
        e.word = word;
        e.busy = busy;
        exp_q.push_back(e);
    endtask

    // Results due in this cycle, sampled half a period after the edge
    always @(negedge clk) begin : compare
        device_state_t act_st;
        int i;
        act_st.dircc_state       = state_main;
        act_st.dircc_state_extra = state_extra;
        act_st.user_state        = state_user;
        i = 0;
        while (i < exp_q.size()) begin
            if (exp_q[i].due == cyc) begin
                case (exp_q[i].kind)
                    KIND_STATE: check_state(act_st, exp_q[i].st, cyc);
                    KIND_WORD:  check_readdata(host_readdata, exp_q[i].word, cyc);
                    default:    check_busy({host_busy, msg_busy}, exp_q[i].busy, cyc);
                endcase
                exp_q.delete(i);
            end else begin
                i++;
            end
        end
    end

    initial begin : watchdog
        wait (cyc >= MAX_CYCLES);
        $display("ERROR: no verdict after %0d cycles, the run hung", MAX_CYCLES);
        $display("FAIL: see errors above");
        $fatal(1, "timeout");
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic host_write_word(input logic [AW-1:0] addr, input logic [15:0] data);
        host_address   = addr;
        host_writedata = data;
        host_write     = 1'b1;
        model = ref_apply(model, 1'b1, 8'h00, data, 64'h0, addr);
        expect_result(1, KIND_STATE, '0, '0);
        next_cycle();
        host_write = 1'b0;
    endtask

    task automatic host_read_word(input logic [AW-1:0] addr);
        host_address = addr;
        expect_result(1, KIND_WORD, ref_read(model, addr), '0);
        next_cycle();
    endtask

    task automatic send_beat(input msg_word_u w);
        msg_data  = w;
        msg_valid = 1'b1;
        next_cycle();
        msg_valid = 1'b0;
    endtask

    task automatic send_hdr(input logic [7:0] op, input logic [15:0] value);
        msg_word_u w;
        bit        known;
        w.hdr.opcode   = msg_opcode_e'(op);
        w.hdr.reserved = 8'($urandom);
        w.hdr.value    = value;
        known = (op == OP_SET_STATE) || (op == OP_SET_EXTRA) || (op == OP_ADD_STATE);
        model = ref_apply(model, 1'b0, op, value, 64'h0, '0);
        expect_result(1, KIND_BUSY, '0, 2'b00);
        expect_result(2, KIND_BUSY, '0, {1'b0, known});   // Busy only while the update shows
        expect_result(3, KIND_STATE, '0, '0);
        send_beat(w);
        next_cycle();
        next_cycle();
    endtask

    task automatic send_user(input logic [31:0] hi, input logic [31:0] lo, input bit stray);
        msg_word_u w;
        w.hdr.opcode   = OP_SET_USER;
        w.hdr.reserved = 8'h00;
        w.hdr.value    = 16'($urandom);
        model = ref_apply(model, 1'b0, OP_SET_USER, 16'h0, {hi, lo}, '0);
        expect_result(1, KIND_BUSY, '0, 2'b01);
        expect_result(4, KIND_BUSY, '0, 2'b01);
        expect_result(5, KIND_STATE, '0, '0);
        send_beat(w);
        w.raw = hi;
        send_beat(w);
        w.raw = lo;
        send_beat(w);
        if (stray) begin
            w.hdr.opcode = OP_SET_STATE;        // Arrive while busy, must be dropped
            w.hdr.value  = 16'($urandom);
            send_beat(w);
            send_beat(w);
            expect_result(1, KIND_STATE, '0, '0);
        end else begin
            next_cycle();
            next_cycle();
        end
    endtask

    // Host write lands in the same cycle as the update strobe
    task automatic update_with_host_write(input logic [7:0] op, input logic [15:0] value,
            input logic [AW-1:0] addr, input logic [15:0] data);
        msg_word_u w;
        w.hdr.opcode   = msg_opcode_e'(op);
        w.hdr.reserved = 8'h00;
        w.hdr.value    = value;
        model = ref_apply(model, 1'b0, op, value, 64'h0, '0);
        expect_result(2, KIND_BUSY, '0, 2'b01);
        expect_result(3, KIND_STATE, '0, '0);
        model = ref_apply(model, 1'b1, 8'h00, data, 64'h0, addr);
        expect_result(3, KIND_BUSY, '0, 2'b10);
        expect_result(4, KIND_STATE, '0, '0);
        expect_result(4, KIND_BUSY, '0, 2'b00);
        send_beat(w);
        next_cycle();
        host_address   = addr;
        host_writedata = data;
        host_write     = 1'b1;
        next_cycle();
        host_write     = 1'b0;
        host_address   = AW'($urandom);         // Replay must keep the buffered address
        host_writedata = 16'($urandom);
        next_cycle();
        next_cycle();
        host_read_word(addr);
    endtask

    task automatic host_random_op();
        if ($urandom % 2 == 1) begin
            host_write_word(AW'($urandom), 16'($urandom));
        end
        host_read_word(AW'($urandom));
    endtask

    initial begin : stimulus
        int drain;
        void'($urandom(32'h0ff5_129b));
        clk            = 1'b0;
        reset_n        = 1'b0;
        host_address   = '0;
        host_write     = 1'b0;
        host_writedata = '0;
        msg_valid      = 1'b0;
        msg_data       = '0;
        model          = '0;
        repeat (16) @(posedge clk);
        #1 reset_n = 1'b1;

        expect_result(0, KIND_STATE, '0, '0);
        expect_result(0, KIND_WORD, 16'h0000, '0);
        expect_result(0, KIND_BUSY, '0, 2'b00);
        next_cycle();

        // Every address, odd ones included, then the out-of-range ones
        for (int a = 0; a <= 10; a++) begin
            host_write_word(AW'(a), 16'($urandom));
        end
        for (int a = 0; a < 16; a++) begin
            host_read_word(AW'(a));
        end
        host_write_word(4'd11, 16'hbeef);
        host_write_word(4'd15, 16'hcafe);
        host_read_word(4'd11);
        host_read_word(4'd10);
        repeat (300) host_random_op();

        send_hdr(OP_SET_STATE, 16'hfff0);
        send_hdr(OP_ADD_STATE, 16'h0025);       // Wraps to 16'h0015
        send_hdr(OP_SET_EXTRA, 16'h5a5a);
        send_hdr(8'h00, 16'h1234);
        send_hdr(8'hff, 16'h4321);
        send_user(32'h0123_4567, 32'h89ab_cdef, 1'b0);
        send_user(32'($urandom), 32'($urandom), 1'b1);
        update_with_host_write(OP_SET_EXTRA, 16'h1357, 4'd2, 16'h2468);
        update_with_host_write(OP_ADD_STATE, 16'h0101, 4'd1, 16'hf00f);

        repeat (250) begin
            case ($urandom % 7)
                0: send_hdr(OP_SET_STATE, 16'($urandom));
                1: send_hdr(OP_SET_EXTRA, 16'($urandom));
                2: send_hdr(OP_ADD_STATE, 16'($urandom));
                3: send_user(32'($urandom), 32'($urandom), ($urandom % 4) == 0);
                4: send_hdr(8'(($urandom % 200) + 16), 16'($urandom));
                5: update_with_host_write(8'(($urandom % 3) + 1), 16'($urandom),
                       AW'($urandom % 11), 16'($urandom));
                default: host_random_op();
            endcase
        end

        drain = 0;
        while (exp_q.size() != 0 && drain < 16) begin
            next_cycle();
            drain++;
        end
        if (exp_q.size() != 0) begin
            $display("ERROR: %0d expected results were never compared", exp_q.size());
            $display("FAIL: see errors above");
            $fatal(1, "unchecked results");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule : dircc_device_tb

// ==== build.f ====
design/dircc_types_pkg.sv
design/dircc_mem_if.sv
design/dircc_status_register.sv
design/dircc_msg_handler.sv
design/dircc_host_arbiter.sv
design/dircc_device_top.sv
tests/dircc_device_sva.sv
tests/dircc_device_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the device testbench with Verilator, run it and look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert --top-module dircc_device_tb -f build.f -o sim_dircc \
    && ./obj_dir/sim_dircc > sim.log 2>&1
[ -f sim.log ] && cat sim.log
grep -q "PASS: all tests" sim.log 2>/dev/null && echo "run_sim: simulation passed" \
    || { echo "run_sim: simulation failed"; exit 1; }
